//--- rtl/nebula_macros.svh
/* Address map and sizing for the user area. One team is wired in the top level today,
   so raising NB_NUM_TEAMS also needs new instances there */
`ifndef NEBULA_MACROS_SVH
`define NEBULA_MACROS_SVH

// Team designs behind the pad and LA muxes, index 0 stays idle
`define NB_NUM_TEAMS 1

// Upper 12 address bits that select the user area
`define NB_BASE_ADR 12'h300

// Two-bit region field starts here
`define NB_REGION_LSB 16

// SRAM depth in 32-bit words
`define NB_SRAM_WORDS 256

// Read data for an address outside the user area
`define NB_UNMAPPED_DATA 32'hDEAD_C0DE

`endif

//--- rtl/wb_pkg.sv
/* Bus-side types of the management Wishbone port. Classic cycles only, 32-bit words,
   no burst or tag signals */
package wb_pkg;

    // Byte address as seen on the bus
    typedef logic [31:0] wb_adr_t;

    // Word data in both directions
    typedef logic [31:0] wb_dat_t;

    typedef logic [3:0] wb_sel_t; // One bit per byte lane

    // Region field of the address, picks the target
    typedef enum logic [1:0] {
        REG_SRAM = 2'd0,
        REG_GPIO = 2'd1,
        REG_LA   = 2'd2,
        REG_TEAM = 2'd3
    } region_e;

endpackage

//--- rtl/pad_pkg.sv
/* Pad and logic-analyzer payloads that teams hand to the output muxes.
   oeb is active low, so an idle GPIO payload leaves every pad undriven */
`include "nebula_macros.svh"

package pad_pkg;

    // 38 pads, value and active-low output enable
    typedef struct packed {
        logic [37:0] out;
        logic [37:0] oeb;
    } gpio_pads_t;

    // 128 logic-analyzer outputs toward the management core
    typedef struct packed {
        logic [127:0] out;
    } la_pads_t;

    // Wide enough to name every team, 0 included
    typedef logic [$clog2(`NB_NUM_TEAMS + 1)-1:0] team_idx_t;

    // Nobody selected
    localparam gpio_pads_t GPIO_IDLE = '{out: '0, oeb: '1};
    localparam la_pads_t LA_IDLE = '{out: '0};

endpackage

//--- rtl/wb_decoder.sv
/* Single-manager Wishbone decoder, request routing and response mux are combinational.
   Addresses outside the base window get a one-cycle ack from here, writes there are dropped */
`include "nebula_macros.svh"

module wb_decoder (
    input  logic            wb_clk_i,
    input  logic            rst_i,

    // Manager side
    input  logic            wbs_cyc_i,
    input  logic            wbs_stb_i,
    input  logic            wbs_we_i,
    input  wb_pkg::wb_sel_t wbs_sel_i,
    input  wb_pkg::wb_adr_t wbs_adr_i,
    input  wb_pkg::wb_dat_t wbs_dat_i,
    output logic            wbs_ack_o,
    output wb_pkg::wb_dat_t wbs_dat_o,

    // Target side, one entry per region
    output logic            cyc_o [wb_pkg::REG_SRAM:wb_pkg::REG_TEAM],
    output logic            stb_o [wb_pkg::REG_SRAM:wb_pkg::REG_TEAM],
    output logic            we_o  [wb_pkg::REG_SRAM:wb_pkg::REG_TEAM],
    output wb_pkg::wb_sel_t sel_o [wb_pkg::REG_SRAM:wb_pkg::REG_TEAM],
    output wb_pkg::wb_adr_t adr_o [wb_pkg::REG_SRAM:wb_pkg::REG_TEAM],
    output wb_pkg::wb_dat_t dat_o [wb_pkg::REG_SRAM:wb_pkg::REG_TEAM],
    input  logic            ack_i [wb_pkg::REG_SRAM:wb_pkg::REG_TEAM],
    input  wb_pkg::wb_dat_t dat_i [wb_pkg::REG_SRAM:wb_pkg::REG_TEAM]
);
    import wb_pkg::*;

    logic    hit;       // Address inside the user area
    region_e region;
    wb_adr_t offset;    // Address with base and region stripped
    logic    unm_ack_q;

    assign hit    = (wbs_adr_i[31:20] == `NB_BASE_ADR);
    assign region = region_e'(wbs_adr_i[`NB_REGION_LSB +: 2]);
    assign offset = wb_adr_t'(wbs_adr_i[`NB_REGION_LSB-1:0]);

    // Only the addressed target sees cyc and stb
    for (genvar r = REG_SRAM; r <= REG_TEAM; r++) begin : g_route
        assign cyc_o[r] = wbs_cyc_i & hit & (region == region_e'(r));
        assign stb_o[r] = wbs_stb_i & hit & (region == region_e'(r));
        assign we_o[r]  = wbs_we_i;
        assign sel_o[r] = wbs_sel_i;
        assign adr_o[r] = offset;
        assign dat_o[r] = wbs_dat_i;
    end

    // Local responder for unmapped requests, same one-cycle wait as the targets
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            unm_ack_q <= 1'b0;
        end else begin
            unm_ack_q <= wbs_cyc_i & wbs_stb_i & ~hit & ~unm_ack_q;
        end
    end

    // Manager holds the address until ack, so the mux stays on the right target
    always_comb begin
        if (hit) begin
            wbs_ack_o = ack_i[region];
            wbs_dat_o = dat_i[region];
        end else begin
            wbs_ack_o = unm_ack_q;
            wbs_dat_o = `NB_UNMAPPED_DATA;
        end
    end

endmodule

//--- rtl/team_output_mux.sv
/* Select register plus team mux for one group of chip outputs. A written select
   reaches the outputs one cycle after its ack, values above the team count give IDLE */
`include "nebula_macros.svh"

module team_output_mux #(
    parameter type      payload_t = logic [31:0],
    parameter payload_t IDLE      = '0
) (
    input  logic            wb_clk_i,
    input  logic            rst_i,

    // Wishbone slave, offset 0 only
    input  logic            cyc_i,
    input  logic            stb_i,
    input  logic            we_i,
    input  wb_pkg::wb_sel_t sel_i,
    input  wb_pkg::wb_dat_t dat_i,
    output logic            ack_o,
    output wb_pkg::wb_dat_t dat_o,

    input  payload_t        designs_i [`NB_NUM_TEAMS+1],
    output payload_t        pads_o
);
    import wb_pkg::*;
    import pad_pkg::*;

    logic [7:0] sel_q;      // Team select, byte 0 of the register
    team_idx_t  team;
    logic       req;

    assign req  = cyc_i & stb_i & ~ack_o;
    assign team = team_idx_t'(sel_q);

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_o <= 1'b0;
            sel_q <= '0;
        end else begin
            ack_o <= req;
            // Commit during the ack cycle, request is still held then
            if (cyc_i && stb_i && we_i && ack_o && sel_i[0]) begin
                sel_q <= dat_i[7:0];
            end
        end
    end

    // Readback is the select zero-extended
    always_ff @(posedge wb_clk_i) begin
        if (req) begin
            dat_o <= wb_dat_t'(sel_q);
        end
    end

    always_comb begin
        if (sel_q > `NB_NUM_TEAMS) begin
            pads_o = IDLE;              // Out of range
        end else begin
            pads_o = designs_i[team];
        end
    end

endmodule

//--- rtl/wb_sram.sv
/* Word SRAM behind a classic Wishbone slave. The word address wraps at the
   depth, contents are undefined after power-up and reset does not clear them */
`include "nebula_macros.svh"

module wb_sram (
    input  logic            wb_clk_i,
    input  logic            rst_i,
    input  logic            cyc_i,
    input  logic            stb_i,
    input  logic            we_i,
    input  wb_pkg::wb_sel_t sel_i,
    input  wb_pkg::wb_adr_t adr_i,   // Byte offset within the region
    input  wb_pkg::wb_dat_t dat_i,
    output logic            ack_o,
    output wb_pkg::wb_dat_t dat_o
);
    import wb_pkg::*;

    localparam int AW = $clog2(`NB_SRAM_WORDS);

    wb_dat_t       mem [`NB_SRAM_WORDS];
    logic [AW-1:0] word;
    logic          req;

    assign word = adr_i[AW+1:2];  // Upper offset bits fold back
    assign req  = cyc_i & stb_i & ~ack_o;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= req;
        end
    end

    // Byte-lane merge on write, old word returned on read
    always_ff @(posedge wb_clk_i) begin
        if (req) begin
            if (we_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (sel_i[b]) begin
                        mem[word][8*b +: 8] <= dat_i[8*b +: 8];
                    end
                end
            end
            dat_o <= mem[word];
        end
    end

endmodule

//--- rtl/sample_team.sv
/* Stand-in team design with one pattern register at offset 0. Drives GPIO 31:0 and
   LA 31:0 only, the upper pads stay undriven and the upper LA bits stay zero */
module sample_team (
    input  logic               wb_clk_i,
    input  logic               rst_i,

    // Wishbone slave
    input  logic               cyc_i,
    input  logic               stb_i,
    input  logic               we_i,
    input  wb_pkg::wb_sel_t    sel_i,
    input  wb_pkg::wb_dat_t    dat_i,
    output logic               ack_o,
    output wb_pkg::wb_dat_t    dat_o,

    input  logic [127:0]       la_data_i,
    output pad_pkg::gpio_pads_t gpio_o,
    output pad_pkg::la_pads_t   la_o
);
    import wb_pkg::*;

    wb_dat_t pattern_q;
    logic    req;

    assign req = cyc_i & stb_i & ~ack_o;

    // Pattern updates on the same edge that raises ack
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_o     <= 1'b0;
            pattern_q <= '0;
        end else begin
            ack_o <= req;
            if (req && we_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (sel_i[b]) begin
                        pattern_q[8*b +: 8] <= dat_i[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (req) begin
            dat_o <= pattern_q;
        end
    end

    // Low 32 pads driven, top 6 left floating
    assign gpio_o = '{out: {6'b0, pattern_q}, oeb: {6'h3f, 32'h0}};

    // Echo of the LA inputs through the pattern
    assign la_o = '{out: {96'b0, pattern_q ^ la_data_i[31:0]}};

endmodule

//--- rtl/nebula_ii.sv
/* User-area top: one Wishbone manager, no arbiter, no master port and no IRQ.
   Team 1 is the sample design, select 0 on either control block gives idle outputs */
`include "nebula_macros.svh"

module nebula_ii (
    input  logic            wb_clk_i,
    input  logic            rst_i,

    // Management Wishbone slave
    input  logic            wbs_cyc_i,
    input  logic            wbs_stb_i,
    input  logic            wbs_we_i,
    input  wb_pkg::wb_sel_t wbs_sel_i,
    input  wb_pkg::wb_adr_t wbs_adr_i,
    input  wb_pkg::wb_dat_t wbs_dat_i,
    output logic            wbs_ack_o,
    output wb_pkg::wb_dat_t wbs_dat_o,

    input  logic [127:0]    la_data_in_i,
    output logic [127:0]    la_data_out_o,
    output logic [37:0]     io_out_o,
    output logic [37:0]     io_oeb_o
);
    import wb_pkg::*;
    import pad_pkg::*;

    // Decoder to target wiring, indexed by region
    logic    dec_cyc [REG_SRAM:REG_TEAM];
    logic    dec_stb [REG_SRAM:REG_TEAM];
    logic    dec_we  [REG_SRAM:REG_TEAM];
    wb_sel_t dec_sel [REG_SRAM:REG_TEAM];
    wb_adr_t dec_adr [REG_SRAM:REG_TEAM];
    wb_dat_t dec_dat [REG_SRAM:REG_TEAM];
    logic    tgt_ack [REG_SRAM:REG_TEAM];
    wb_dat_t tgt_dat [REG_SRAM:REG_TEAM];

    gpio_pads_t designs_gpio [`NB_NUM_TEAMS+1];
    la_pads_t   designs_la   [`NB_NUM_TEAMS+1];
    gpio_pads_t gpio_pads;
    la_pads_t   la_pads;

    assign designs_gpio[0] = GPIO_IDLE;
    assign designs_la[0]   = LA_IDLE;

    wb_decoder u_decoder (
        .wb_clk_i, .rst_i,
        .wbs_cyc_i, .wbs_stb_i, .wbs_we_i, .wbs_sel_i, .wbs_adr_i, .wbs_dat_i,
        .wbs_ack_o, .wbs_dat_o,
        .cyc_o(dec_cyc), .stb_o(dec_stb), .we_o(dec_we), .sel_o(dec_sel),
        .adr_o(dec_adr), .dat_o(dec_dat), .ack_i(tgt_ack), .dat_i(tgt_dat)
    );

    wb_sram u_sram (
        .wb_clk_i, .rst_i,
        .cyc_i(dec_cyc[REG_SRAM]), .stb_i(dec_stb[REG_SRAM]), .we_i(dec_we[REG_SRAM]),
        .sel_i(dec_sel[REG_SRAM]), .adr_i(dec_adr[REG_SRAM]), .dat_i(dec_dat[REG_SRAM]),
        .ack_o(tgt_ack[REG_SRAM]), .dat_o(tgt_dat[REG_SRAM])
    );

    team_output_mux #(.payload_t(gpio_pads_t), .IDLE(GPIO_IDLE)) gpio_ctrl (
        .wb_clk_i, .rst_i,
        .cyc_i(dec_cyc[REG_GPIO]), .stb_i(dec_stb[REG_GPIO]), .we_i(dec_we[REG_GPIO]),
        .sel_i(dec_sel[REG_GPIO]), .dat_i(dec_dat[REG_GPIO]),
        .ack_o(tgt_ack[REG_GPIO]), .dat_o(tgt_dat[REG_GPIO]),
        .designs_i(designs_gpio), .pads_o(gpio_pads)
    );

    team_output_mux #(.payload_t(la_pads_t), .IDLE(LA_IDLE)) la_ctrl (
        .wb_clk_i, .rst_i,
        .cyc_i(dec_cyc[REG_LA]), .stb_i(dec_stb[REG_LA]), .we_i(dec_we[REG_LA]),
        .sel_i(dec_sel[REG_LA]), .dat_i(dec_dat[REG_LA]),
        .ack_o(tgt_ack[REG_LA]), .dat_o(tgt_dat[REG_LA]),
        .designs_i(designs_la), .pads_o(la_pads)
    );

    // Team 1, swap in a real team design here
    sample_team u_team (
        .wb_clk_i, .rst_i,
        .cyc_i(dec_cyc[REG_TEAM]), .stb_i(dec_stb[REG_TEAM]), .we_i(dec_we[REG_TEAM]),
        .sel_i(dec_sel[REG_TEAM]), .dat_i(dec_dat[REG_TEAM]),
        .ack_o(tgt_ack[REG_TEAM]), .dat_o(tgt_dat[REG_TEAM]),
        .la_data_i(la_data_in_i), .gpio_o(designs_gpio[1]), .la_o(designs_la[1])
    );

    assign io_out_o      = gpio_pads.out;
    assign io_oeb_o      = gpio_pads.oeb;   // Active low
    assign la_data_out_o = la_pads.out;

endmodule

//--- testbench/nebula_ii_props.sv
/* Wishbone handshake and reset-state assertions, bound into nebula_ii.
   Assumes a single manager that holds its request through the ack cycle */
module nebula_ii_props (
    input logic         clk_i,
    input logic         rst_i,
    input logic         cyc_i,
    input logic         stb_i,
    input logic         ack_i,
    input logic [37:0]  io_out_i,
    input logic [37:0]  io_oeb_i,
    input logic [127:0] la_out_i
);
    timeunit 1ns;
    timeprecision 1ns;

    int   fail_cnt = 0;     // Total assertion failures
    logic req_new;          // Request not yet answered

    assign req_new = cyc_i & stb_i & ~ack_i;

    // Pads idle and LA quiet on the first cycle out of reset
    a_reset_idle: assert property (@(posedge clk_i)
        $fell(rst_i) |-> (io_oeb_i == '1 && io_out_i == '0 && la_out_i == '0))
        else begin
            fail_cnt++;
            $error("Outputs not idle on the first cycle after reset");
        end

    a_reset_ack: assert property (@(posedge clk_i) rst_i |=> !ack_i)
        else begin
            fail_cnt++;
            $error("Ack high after a reset cycle");
        end

    // Every sampled request is answered on the next edge
    a_ack_next: assert property (@(posedge clk_i) disable iff (rst_i)
        req_new |=> ack_i)
        else begin
            fail_cnt++;
            $error("Request was not acknowledged one cycle after it was sampled");
        end

    a_ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
        ack_i |=> !ack_i)
        else begin
            fail_cnt++;
            $error("Ack lasted more than one cycle");
        end

    // No ack without a request on the bus
    a_ack_has_req: assert property (@(posedge clk_i) disable iff (rst_i)
        ack_i |-> (cyc_i && stb_i))
        else begin
            fail_cnt++;
            $error("Ack raised while no request was present");
        end

endmodule

bind nebula_ii nebula_ii_props u_props (
    .clk_i(wb_clk_i), .rst_i(rst_i),
    .cyc_i(wbs_cyc_i), .stb_i(wbs_stb_i), .ack_i(wbs_ack_o),
    .io_out_i(io_out_o), .io_oeb_i(io_oeb_o), .la_out_i(la_data_out_o)
);

//--- testbench/nebula_ii_tb.sv
/* Directed and xorshift-random Wishbone traffic for nebula_ii. Data checks are immediate
   assertions here, handshake and reset rules live in the bound props module */
`include "nebula_macros.svh"

module nebula_ii_tb;
    timeunit 1ns;
    timeprecision 1ns;

    import wb_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int N_FULL         = 16;    // Full-word SRAM writes, each read back
    localparam int N_PART         = 8;     // Byte-select rewrites of earlier words
    localparam int NUM_TXNS       = 2 * N_FULL + N_PART + 13;
    localparam int TIMEOUT_CYCLES = NUM_TXNS * 4 + 100;

    logic         wb_clk;
    logic         rst;
    logic         wbs_cyc;
    logic         wbs_stb;
    logic         wbs_we;
    wb_sel_t      wbs_sel;
    wb_adr_t      wbs_adr;
    wb_dat_t      wbs_dat;
    logic         wbs_ack;
    wb_dat_t      wbs_dat_o;
    logic [127:0] la_data_in;
    logic [127:0] la_data_out;
    logic [37:0]  io_out;
    logic [37:0]  io_oeb;

    logic [31:0]  rng = 32'h44f3f1bb;
    int           errors = 0;
    wb_dat_t      shadow [`NB_SRAM_WORDS];   // Expected SRAM contents
    logic [7:0]   idx_q [$];                  // Words written so far
    logic [7:0]   idx;
    wb_sel_t      byte_sel;
    wb_dat_t      rdata;
    wb_dat_t      pattern;                    // Expected team pattern

    nebula_ii dut_i (
        .wb_clk_i(wb_clk), .rst_i(rst),
        .wbs_cyc_i(wbs_cyc), .wbs_stb_i(wbs_stb), .wbs_we_i(wbs_we),
        .wbs_sel_i(wbs_sel), .wbs_adr_i(wbs_adr), .wbs_dat_i(wbs_dat),
        .wbs_ack_o(wbs_ack), .wbs_dat_o(wbs_dat_o),
        .la_data_in_i(la_data_in), .la_data_out_o(la_data_out),
        .io_out_o(io_out), .io_oeb_o(io_oeb)
    );

    initial begin
        wb_clk = 1'b0;
        forever #(CLK_PERIOD / 2) wb_clk = ~wb_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Only the lanes with a select bit take the new byte
    function automatic wb_dat_t merge_bytes(input wb_dat_t old, input wb_dat_t wr,
                                            input wb_sel_t s);
        wb_dat_t m;
        m = old;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                m[8*b +: 8] = wr[8*b +: 8];
            end
        end
        return m;
    endfunction

    function automatic wb_adr_t region_adr(input region_e region, input logic [15:0] offset);
        return {`NB_BASE_ADR, 2'b00, region, offset};
    endfunction

    function automatic wb_adr_t sram_adr(input logic [7:0] word);
        return region_adr(REG_SRAM, {6'b0, word, 2'b00});
    endfunction

    task automatic check_val(input string name, input logic [127:0] exp,
                             input logic [127:0] got);
        assert (got == exp) else begin
            errors++;
            $display("ERR %s exp=%0h got=%0h", name, exp, got);
        end
    endtask

    // Request held through the ack cycle, released on the next falling edge
    task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_dat_t dat,
                             input wb_sel_t sel, output wb_dat_t data);
        @(negedge wb_clk);
        wbs_cyc = 1'b1;
        wbs_stb = 1'b1;
        wbs_we  = we;
        wbs_sel = sel;
        wbs_adr = adr;
        wbs_dat = dat;
        @(negedge wb_clk);
        while (!wbs_ack) @(negedge wb_clk);
        data = wbs_dat_o;
        @(negedge wb_clk);
        wbs_cyc = 1'b0;
        wbs_stb = 1'b0;
        wbs_we  = 1'b0;
    endtask

    task automatic write_word(input wb_adr_t adr, input wb_dat_t dat, input wb_sel_t sel);
        wb_dat_t ignored;
        bus_cycle(1'b1, adr, dat, sel, ignored);
    endtask

    task automatic read_word(input wb_adr_t adr, output wb_dat_t data);
        bus_cycle(1'b0, adr, '0, 4'hf, data);
    endtask

    initial begin
        wbs_cyc = 1'b0;
        wbs_stb = 1'b0;
        wbs_we  = 1'b0;
        wbs_sel = '0;
        wbs_adr = '0;
        wbs_dat = '0;
        rng = xorshift32(rng);
        la_data_in = {rng, ~rng, rng, rng};
        rst = 1'b1;
        repeat (4) @(negedge wb_clk);
        rst = 1'b0;
        @(negedge wb_clk);
        check_val("io_oeb_o", 128'({38{1'b1}}), 128'(io_oeb));
        check_val("io_out_o", 128'h0, 128'(io_out));
        check_val("la_data_out_o", 128'h0, la_data_out);

        for (int i = 0; i < N_FULL; i++) begin
            rng = xorshift32(rng);
            idx = rng[7:0];
            rng = xorshift32(rng);
            write_word(sram_adr(idx), rng, 4'hf);
            shadow[idx] = rng;
            idx_q.push_back(idx);
        end
        for (int i = 0; i < N_PART; i++) begin
            idx = idx_q[i];
            rng = xorshift32(rng);
            byte_sel = rng[3:0];
            rng = xorshift32(rng);
            write_word(sram_adr(idx), rng, byte_sel);
            shadow[idx] = merge_bytes(shadow[idx], rng, byte_sel);
        end
        foreach (idx_q[i]) begin
            read_word(sram_adr(idx_q[i]), rdata);
            check_val($sformatf("wbs_dat_o sram[%0d]", idx_q[i]), 128'(shadow[idx_q[i]]),
                      128'(rdata));
        end

        // Outside the base window, low bits alias an SRAM word that must not change
        read_word(32'h1230_0040, rdata);
        check_val("wbs_dat_o unmapped", 128'(`NB_UNMAPPED_DATA), 128'(rdata));
        write_word({12'h100, 2'b00, REG_SRAM, 6'b0, idx_q[0], 2'b00}, ~shadow[idx_q[0]], 4'hf);
        read_word(sram_adr(idx_q[0]), rdata);
        check_val("wbs_dat_o sram after unmapped write", 128'(shadow[idx_q[0]]), 128'(rdata));

        rng = xorshift32(rng);
        pattern = rng;
        write_word(region_adr(REG_TEAM, 16'h0), pattern, 4'hf);
        read_word(region_adr(REG_TEAM, 16'h0), rdata);
        check_val("wbs_dat_o team pattern", 128'(pattern), 128'(rdata));
        write_word(region_adr(REG_GPIO, 16'h0), 32'd1, 4'h1);
        write_word(region_adr(REG_LA, 16'h0), 32'd1, 4'h1);
        read_word(region_adr(REG_GPIO, 16'h0), rdata);
        check_val("wbs_dat_o gpio select", 128'd1, 128'(rdata));
        read_word(region_adr(REG_LA, 16'h0), rdata);
        check_val("wbs_dat_o la select", 128'd1, 128'(rdata));
        check_val("io_out_o", 128'({6'h0, pattern}), 128'(io_out));
        check_val("io_oeb_o", 128'({6'h3f, 32'h0}), 128'(io_oeb));
        check_val("la_data_out_o", {96'h0, pattern ^ la_data_in[31:0]}, la_data_out);
        la_data_in = ~la_data_in;          // LA path is combinational through the team
        @(negedge wb_clk);
        check_val("la_data_out_o", {96'h0, pattern ^ la_data_in[31:0]}, la_data_out);

        // Select 2 has no team behind it
        write_word(region_adr(REG_GPIO, 16'h0), 32'd2, 4'h1);
        write_word(region_adr(REG_LA, 16'h0), 32'd2, 4'h1);
        check_val("io_oeb_o", 128'({38{1'b1}}), 128'(io_oeb));
        check_val("io_out_o", 128'h0, 128'(io_out));
        check_val("la_data_out_o", 128'h0, la_data_out);

        // Select 3 is out of range too, its low index bit would name team 1
        write_word(region_adr(REG_GPIO, 16'h0), 32'd3, 4'h1);
        write_word(region_adr(REG_LA, 16'h0), 32'd3, 4'h1);
        check_val("io_oeb_o", 128'({38{1'b1}}), 128'(io_oeb));
        check_val("io_out_o", 128'h0, 128'(io_out));
        check_val("la_data_out_o", 128'h0, la_data_out);

        repeat (3) @(negedge wb_clk);
        $display("Errors: %0d value, %0d property", errors, dut_i.u_props.fail_cnt);
        if (errors == 0 && dut_i.u_props.fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Watchdog expired, a Wishbone cycle never completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- project.f
+incdir+rtl
rtl/wb_pkg.sv
rtl/pad_pkg.sv
rtl/wb_decoder.sv
rtl/team_output_mux.sv
rtl/wb_sram.sv
rtl/sample_team.sv
rtl/nebula_ii.sv
testbench/nebula_ii_props.sv
testbench/nebula_ii_tb.sv

//--- Makefile
# Verilator build and run for the nebula_ii testbench
VERILATOR ?= verilator
TOP       ?= nebula_ii_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation finished: PASS

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard rtl/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
